// File: include/dac_ctrl_config.svh
// DAC control subsystem
// build-time configuration

`ifndef DAC_CTRL_CONFIG_SVH
`define DAC_CTRL_CONFIG_SVH

// bus geometry, word addressed
`define DAC_DATA_W          16
`define DAC_ADDR_W          4

// register map
`define DAC_REG_ID          0
`define DAC_REG_VERSION     1
`define DAC_REG_DAC         2   // frame word sent to the DAC
`define DAC_REG_EN_MMI      3   // read-only copy of en_mmi_ctrl
`define DAC_NUM_REGS        4

// identification
`define DAC_MODULE_ID       10
`define DAC_MODULE_VERSION  1

// DAC register contents after reset
`define DAC_DEFAULT         100

// gain field inside the DAC register, bits 13..6
`define DAC_GAIN_LSB        6
`define DAC_GAIN_W          8

// system clocks per half sclk period
`define DAC_SPI_CLK_DIV     4

`endif

// File: hw/mmi_pkg.sv
// memory-mapped bus types

`default_nettype none

`include "dac_ctrl_config.svh"

package mmi_pkg;

    // word address and data word
    typedef logic [`DAC_ADDR_W-1:0] mmi_addr_t;
    typedef logic [`DAC_DATA_W-1:0] mmi_data_t;

    // write request, qualified by wr_valid
    typedef struct packed {
        mmi_addr_t addr;
        mmi_data_t data;
    } mmi_wr_req_t;

    // read response, valid one cycle after the read is taken
    typedef struct packed {
        logic      valid;
        mmi_data_t data;
    } mmi_rd_rsp_t;

endpackage

`default_nettype wire

// File: hw/dac_pkg.sv
// DAC frame and sequencing types

`default_nettype none

`include "dac_ctrl_config.svh"

package dac_pkg;

    typedef logic [`DAC_DATA_W-1:0] dac_word_t;    // one serial frame
    typedef logic [`DAC_GAIN_W-1:0] dac_gain_t;    // gain field of the frame

    // three-wire DAC interface
    typedef struct packed {
        logic sclk;
        logic sync_n;
        logic sdo;
    } dac_spi_pins_t;

    // frame sequencer in the controller
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_START,   // spi_valid high, waiting for the serializer
        SEQ_BUSY     // frame on the wires
    } dac_seq_state_t;

    // serializer
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_FINISH   // sync_n back high, done pulse
    } spi_state_t;

endpackage

`default_nettype wire

// File: hw/dac_ad5601_ctrl_mmi.sv
// AD5601 register block
// and frame sequencer

`default_nettype none

`include "dac_ctrl_config.svh"

module dac_ad5601_ctrl_mmi
    import mmi_pkg::*;
    import dac_pkg::*;
(
    input  wire logic        clk_ifc,
    input  wire logic        set_default_on_reset,
    input  wire logic        en_mmi_ctrl,       // 1: bus owns the DAC register
    input  wire mmi_wr_req_t mmi_wr,
    input  wire logic        wr_valid,
    input  wire mmi_addr_t   rd_addr,
    input  wire logic        rd_valid,
    input  wire dac_gain_t   gain,
    input  wire logic        gain_valid,
    input  wire logic        spi_ready,
    input  wire logic        spi_done,
    output logic             wr_ready,
    output logic             rd_ready,
    output mmi_rd_rsp_t      rd_rsp,
    output logic             gain_ready,
    output dac_word_t        spi_word,
    output logic             spi_valid
);

    localparam int REG_IDX_W = $clog2(`DAC_NUM_REGS);

    logic           if_active_q;                 // interfaces open
    logic           wr_fire;
    logic           rd_fire;
    logic           gain_fire;
    logic           dac_wr_hit;
    dac_word_t      dac_reg_q;
    logic           dac_changed_q;               // register changed last edge
    mmi_data_t      reg_view [`DAC_NUM_REGS];
    logic           rd_valid_q;
    mmi_data_t      rd_data_q;
    dac_seq_state_t seq_state_q;
    logic           pending_q;                   // change seen during a frame

    //////////////////////////////////////////////////
    // handshakes

    // ready opens on the first edge after reset
    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            if_active_q <= 1'b0;
        end else begin
            if_active_q <= 1'b1;
        end
    end

    assign wr_ready   = if_active_q;
    assign rd_ready   = if_active_q;
    assign gain_ready = if_active_q & ~en_mmi_ctrl;  // gain port only when bus is off

    assign wr_fire   = wr_valid & wr_ready;
    assign rd_fire   = rd_valid & rd_ready;
    assign gain_fire = gain_valid & gain_ready;

    // only the DAC register takes writes, and only under bus control
    assign dac_wr_hit = wr_fire & en_mmi_ctrl &
                        (mmi_wr.addr == mmi_addr_t'(`DAC_REG_DAC));

    //////////////////////////////////////////////////
    // DAC register

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            dac_reg_q     <= dac_word_t'(`DAC_DEFAULT);
            dac_changed_q <= 1'b0;
        end else begin
            if (dac_wr_hit) begin
                dac_reg_q <= mmi_wr.data;
            end else if (gain_fire) begin
                dac_reg_q[`DAC_GAIN_LSB +: `DAC_GAIN_W] <= gain;  // gain bits only
            end
            dac_changed_q <= dac_wr_hit | gain_fire;
        end
    end

    //////////////////////////////////////////////////
    // read path

    always_comb begin
        reg_view[`DAC_REG_ID]      = mmi_data_t'(`DAC_MODULE_ID);
        reg_view[`DAC_REG_VERSION] = mmi_data_t'(`DAC_MODULE_VERSION);
        reg_view[`DAC_REG_DAC]     = dac_reg_q;
        reg_view[`DAC_REG_EN_MMI]  = mmi_data_t'(en_mmi_ctrl);   // bit 0, zero above
    end

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_fire;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (rd_fire) begin
            if (rd_addr < mmi_addr_t'(`DAC_NUM_REGS)) begin
                rd_data_q <= reg_view[rd_addr[REG_IDX_W-1:0]];
            end else begin
                rd_data_q <= '0;                   // unmapped words read zero
            end
        end
    end

    assign rd_rsp = '{valid: rd_valid_q, data: rd_data_q};

    //////////////////////////////////////////////////
    // frame sequencer

    // a frame goes out after reset and after every change; changes
    // during a frame fold into one follow-up frame with the latest value
    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            seq_state_q <= SEQ_START;              // default frame first
            spi_word    <= dac_word_t'(`DAC_DEFAULT);
            pending_q   <= 1'b0;
        end else begin
            case (seq_state_q)
                SEQ_IDLE: begin
                    if (dac_changed_q) begin
                        spi_word    <= dac_reg_q;
                        seq_state_q <= SEQ_START;
                    end
                end
                SEQ_START: begin
                    if (dac_changed_q) begin
                        pending_q <= 1'b1;         // latched word is already stale
                    end
                    if (spi_ready) begin
                        seq_state_q <= SEQ_BUSY;
                    end
                end
                SEQ_BUSY: begin
                    if (spi_done) begin
                        pending_q <= 1'b0;
                        if (pending_q | dac_changed_q) begin
                            spi_word    <= dac_reg_q;  // value as it stands now
                            seq_state_q <= SEQ_START;
                        end else begin
                            seq_state_q <= SEQ_IDLE;
                        end
                    end else if (dac_changed_q) begin
                        pending_q <= 1'b1;
                    end
                end
                default: begin
                    seq_state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    assign spi_valid = (seq_state_q == SEQ_START);

endmodule

`default_nettype wire

// File: hw/dac_spi_master.sv
// DAC three-wire serializer

`default_nettype none

`include "dac_ctrl_config.svh"

module dac_spi_master
    import dac_pkg::*;
(
    input  wire logic      clk_ifc,
    input  wire logic      set_default_on_reset,
    input  wire dac_word_t spi_word,
    input  wire logic      spi_valid,
    output logic           spi_ready,
    output logic           spi_done,
    output dac_spi_pins_t  pins
);

    localparam int DIV   = `DAC_SPI_CLK_DIV;
    localparam int DIV_W = $clog2(2 * DIV);
    localparam int NBITS = $bits(dac_word_t);
    localparam int BIT_W = $clog2(NBITS);

    spi_state_t       state_q;
    logic [DIV_W-1:0] div_cnt_q;       // position inside one sclk period
    logic [BIT_W-1:0] bit_cnt_q;
    dac_word_t        shift_q;
    logic             period_end;
    logic             last_bit;

    assign spi_ready  = (state_q == SPI_IDLE);
    assign spi_done   = (state_q == SPI_FINISH);   // one cycle, sync_n already high
    assign period_end = (div_cnt_q == DIV_W'(2 * DIV - 1));
    assign last_bit   = (bit_cnt_q == BIT_W'(NBITS - 1));

    //////////////////////////////////////////////////
    // control and pins

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state_q     <= SPI_IDLE;
            div_cnt_q   <= '0;
            bit_cnt_q   <= '0;
            pins.sclk   <= 1'b0;
            pins.sync_n <= 1'b1;
            pins.sdo    <= 1'b0;
        end else begin
            case (state_q)
                SPI_IDLE: begin
                    if (spi_valid) begin
                        state_q     <= SPI_SHIFT;
                        pins.sync_n <= 1'b0;       // falls one cycle after accept
                        div_cnt_q   <= '0;
                        bit_cnt_q   <= '0;
                    end
                end
                SPI_SHIFT: begin
                    div_cnt_q <= period_end ? '0 : div_cnt_q + 1'b1;
                    if (div_cnt_q == '0) begin
                        pins.sclk <= 1'b1;
                        pins.sdo  <= shift_q[NBITS-1];  // new bit on rising sclk
                    end
                    if (div_cnt_q == DIV_W'(DIV)) begin
                        pins.sclk <= 1'b0;          // DAC samples here
                    end
                    if (period_end) begin
                        if (last_bit) begin
                            state_q     <= SPI_FINISH;
                            pins.sync_n <= 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= SPI_IDLE;           // FINISH lasts one cycle
                end
            endcase
        end
    end

    // frame word, MSB first
    always_ff @(posedge clk_ifc) begin
        if (spi_valid & spi_ready) begin
            shift_q <= spi_word;
        end else if ((state_q == SPI_SHIFT) && (div_cnt_q == '0)) begin
            shift_q <= {shift_q[NBITS-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: hw/dac_ad5601_subsys.sv
// AD5601 DAC control subsystem

`default_nettype none

module dac_ad5601_subsys
    import mmi_pkg::*;
    import dac_pkg::*;
(
    input  wire logic        clk_ifc,
    input  wire logic        set_default_on_reset,
    input  wire logic        en_mmi_ctrl,
    input  wire mmi_wr_req_t mmi_wr,
    input  wire logic        wr_valid,
    input  wire mmi_addr_t   rd_addr,
    input  wire logic        rd_valid,
    input  wire dac_gain_t   gain,
    input  wire logic        gain_valid,
    output logic             wr_ready,
    output logic             rd_ready,
    output mmi_rd_rsp_t      rd_rsp,
    output logic             gain_ready,
    output logic             dac_updated,   // frame finished
    output dac_spi_pins_t    pins
);

    dac_word_t spi_word;
    logic      spi_valid;
    logic      spi_ready;

    dac_ad5601_ctrl_mmi dac_ad5601_ctrl_mmi_inst (
        .clk_ifc              ( clk_ifc              ),
        .set_default_on_reset ( set_default_on_reset ),
        .en_mmi_ctrl          ( en_mmi_ctrl          ),
        .mmi_wr               ( mmi_wr               ),
        .wr_valid             ( wr_valid             ),
        .rd_addr              ( rd_addr              ),
        .rd_valid             ( rd_valid             ),
        .gain                 ( gain                 ),
        .gain_valid           ( gain_valid           ),
        .spi_ready            ( spi_ready            ),
        .spi_done             ( dac_updated          ),
        .wr_ready             ( wr_ready             ),
        .rd_ready             ( rd_ready             ),
        .rd_rsp               ( rd_rsp               ),
        .gain_ready           ( gain_ready           ),
        .spi_word             ( spi_word             ),
        .spi_valid            ( spi_valid            )
    );

    dac_spi_master dac_spi_master_inst (
        .clk_ifc              ( clk_ifc              ),
        .set_default_on_reset ( set_default_on_reset ),
        .spi_word             ( spi_word             ),
        .spi_valid            ( spi_valid            ),
        .spi_ready            ( spi_ready            ),
        .spi_done             ( dac_updated          ),
        .pins                 ( pins                 )
    );

endmodule

`default_nettype wire

// File: testbench/tb_dac_ad5601_subsys.sv
// AD5601 subsystem testbench

`default_nettype none

`include "dac_ctrl_config.svh"

module tb_dac_ad5601_subsys
    import mmi_pkg::*;
    import dac_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          READY_TIMEOUT = 50;
    localparam int          FRAME_TIMEOUT = 400;   // one frame is about 130 cycles
    localparam int          QUIET_CYCLES  = 12;
    localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

    logic          clk_ifc;
    logic          set_default_on_reset;
    logic          en_mmi_ctrl;
    mmi_wr_req_t   mmi_wr;
    logic          wr_valid;
    mmi_addr_t     rd_addr;
    logic          rd_valid;
    dac_gain_t     gain;
    logic          gain_valid;
    logic          wr_ready;
    logic          rd_ready;
    mmi_rd_rsp_t   rd_rsp;
    logic          gain_ready;
    logic          dac_updated;
    dac_spi_pins_t pins;

    logic [31:0] lfsr_state = 32'h27e33127;
    dac_word_t   model_dac  = `DAC_DEFAULT;    // expected DAC register
    dac_word_t   hist0;                        // model after the last three edges
    dac_word_t   hist1;
    dac_word_t   hist2;
    dac_word_t   snap;
    dac_word_t   rx_word;
    dac_word_t   last_frame;
    int          rx_bits;
    int          frames_rx  = 0;
    int          updates    = 0;
    logic        in_frame   = 1'b0;
    logic        sclk_prev  = 1'b0;
    logic        sync_prev  = 1'b1;
    logic        reset_edge = 1'b1;            // last rising edge was a reset edge

    dac_ad5601_subsys dac_ad5601_subsys_inst (
        .clk_ifc              ( clk_ifc              ),
        .set_default_on_reset ( set_default_on_reset ),
        .en_mmi_ctrl          ( en_mmi_ctrl          ),
        .mmi_wr               ( mmi_wr               ),
        .wr_valid             ( wr_valid             ),
        .rd_addr              ( rd_addr              ),
        .rd_valid             ( rd_valid             ),
        .gain                 ( gain                 ),
        .gain_valid           ( gain_valid           ),
        .wr_ready             ( wr_ready             ),
        .rd_ready             ( rd_ready             ),
        .rd_rsp               ( rd_rsp               ),
        .gain_ready           ( gain_ready           ),
        .dac_updated          ( dac_updated          ),
        .pins                 ( pins                 )
    );

    initial begin
        clk_ifc = 1'b0;
        forever #2 clk_ifc = ~clk_ifc;
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
                                name, got, expected));
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic mmi_data_t expected_read(input mmi_addr_t addr);
        case (int'(addr))
            `DAC_REG_ID:      return mmi_data_t'(`DAC_MODULE_ID);
            `DAC_REG_VERSION: return mmi_data_t'(`DAC_MODULE_VERSION);
            `DAC_REG_DAC:     return model_dac;
            `DAC_REG_EN_MMI:  return mmi_data_t'(en_mmi_ctrl);   // bit 0 only
            default:          return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // bus and gain drivers, entered and left at a falling edge

    task automatic apply_reset();
        set_default_on_reset = 1'b1;
        @(posedge clk_ifc);
        model_dac = `DAC_DEFAULT;
        repeat (7) @(posedge clk_ifc);
        @(negedge clk_ifc);
        set_default_on_reset = 1'b0;
    endtask

    task automatic write_reg(input mmi_addr_t addr, input mmi_data_t data);
        int waited;
        waited   = 0;
        mmi_wr   = '{addr: addr, data: data};
        wr_valid = 1'b1;
        while (wr_ready !== 1'b1) begin
            @(negedge clk_ifc);
            waited++;
            if (waited > READY_TIMEOUT) abort_run("timeout: write ready never came");
        end
        @(posedge clk_ifc);
        if (en_mmi_ctrl && addr == mmi_addr_t'(`DAC_REG_DAC)) begin
            model_dac = data;                  // other writes are dropped
        end
        @(negedge clk_ifc);
        wr_valid = 1'b0;
    endtask

    task automatic send_gain(input dac_gain_t g);
        int waited;
        waited     = 0;
        gain       = g;
        gain_valid = 1'b1;
        while (gain_ready !== 1'b1) begin
            @(negedge clk_ifc);
            waited++;
            if (waited > READY_TIMEOUT) abort_run("timeout: gain ready never came");
        end
        @(posedge clk_ifc);
        model_dac[`DAC_GAIN_LSB +: `DAC_GAIN_W] = g;
        @(negedge clk_ifc);
        gain_valid = 1'b0;
    endtask

    task automatic read_expect(input mmi_addr_t addr, input mmi_data_t expected);
        int waited;
        waited   = 0;
        rd_addr  = addr;
        rd_valid = 1'b1;
        while (rd_ready !== 1'b1) begin
            @(negedge clk_ifc);
            waited++;
            if (waited > READY_TIMEOUT) abort_run("timeout: read ready never came");
        end
        @(posedge clk_ifc);
        @(negedge clk_ifc);
        rd_valid = 1'b0;
        waited   = 1;
        while (rd_rsp.valid !== 1'b1) begin
            @(negedge clk_ifc);
            waited++;
            if (waited > READY_TIMEOUT) abort_run("timeout: read response never came");
        end
        check_value("rd_rsp latency", waited, 1);
        check_value($sformatf("rd_rsp.data[%0d]", addr), rd_rsp.data, expected);
    endtask

    task automatic change_dac();
        if (en_mmi_ctrl) begin
            write_reg(mmi_addr_t'(`DAC_REG_DAC), mmi_data_t'(rand_bits(16)));
        end else begin
            send_gain(dac_gain_t'(rand_bits(8)));
        end
    endtask

    task automatic wait_frames(input int target);
        int waited;
        waited = 0;
        do begin
            @(posedge clk_ifc);
            waited++;
            if (waited > FRAME_TIMEOUT) abort_run("timeout: expected DAC frame never arrived");
        end while (frames_rx < target);
        @(negedge clk_ifc);
    endtask

    task automatic wait_sync_low();
        int waited;
        waited = 0;
        do begin
            @(negedge clk_ifc);
            waited++;
            if (waited > FRAME_TIMEOUT) abort_run("timeout: sync_n never went low");
        end while (pins.sync_n !== 1'b0);
    endtask

    task automatic wait_quiet();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk_ifc);
            waited++;
            if (waited > 3 * FRAME_TIMEOUT) abort_run("timeout: frame traffic never settled");
            quiet = (pins.sync_n === 1'b1) ? quiet + 1 : 0;
        end
    endtask

    //////////////////////////////////////////////////
    // frame receiver

    always @(posedge clk_ifc) begin
        reset_edge <= set_default_on_reset;
    end

    // a frame carries the register as it stood two edges before sync_n fell
    always @(negedge clk_ifc) begin
        hist2 = hist1;
        hist1 = hist0;
        hist0 = model_dac;
        if (dac_updated === 1'b1) updates++;
        if (sync_prev === 1'b1 && pins.sync_n === 1'b0) begin
            in_frame = 1'b1;
            rx_bits  = 0;
            rx_word  = '0;
            snap     = hist2;
        end else if (in_frame && pins.sync_n === 1'b1) begin
            in_frame = 1'b0;
            if (!reset_edge) begin             // frames cut by reset are dropped
                check_value("frame bit count", rx_bits, $bits(dac_word_t));
                check_value("frame word", rx_word, snap);
                last_frame = rx_word;
                frames_rx++;
            end
        end else if (in_frame && sclk_prev === 1'b1 && pins.sclk === 1'b0) begin
            rx_word = {rx_word[$bits(dac_word_t)-2:0], pins.sdo};   // MSB first
            rx_bits++;
        end
        sclk_prev = pins.sclk;
        sync_prev = pins.sync_n;
    end

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        int        i;
        int        n_frames;
        mmi_addr_t addr;
        dac_gain_t g;

        set_default_on_reset = 1'b1;
        en_mmi_ctrl          = 1'b1;
        mmi_wr               = '0;
        wr_valid             = 1'b0;
        rd_addr              = '0;
        rd_valid             = 1'b0;
        gain                 = '0;
        gain_valid           = 1'b0;
        apply_reset();

        // default frame and identification
        wait_frames(1);
        check_value("first frame", last_frame, `DAC_DEFAULT);
        check_value("wr_ready", wr_ready, 1'b1);
        check_value("rd_ready", rd_ready, 1'b1);
        read_expect(mmi_addr_t'(`DAC_REG_ID), `DAC_MODULE_ID);
        read_expect(mmi_addr_t'(`DAC_REG_VERSION), `DAC_MODULE_VERSION);

        for (i = 0; i < 24; i++) begin
            if (rand_bits(3) == 0) en_mmi_ctrl = (rand_bits(1) != 0);
            addr = mmi_addr_t'(rand_bits(4));
            read_expect(addr, expected_read(addr));
        end

        // bus writes under bus control
        en_mmi_ctrl = 1'b1;
        for (i = 0; i < 6; i++) begin
            n_frames = frames_rx;
            change_dac();
            wait_frames(n_frames + 1);
            check_value("frame after write", last_frame, model_dac);
            read_expect(mmi_addr_t'(`DAC_REG_DAC), expected_read(`DAC_REG_DAC));
        end

        // writes that must be dropped
        n_frames = frames_rx;
        write_reg(mmi_addr_t'(`DAC_REG_ID), mmi_data_t'(rand_bits(16)));
        write_reg(mmi_addr_t'(`DAC_REG_VERSION), mmi_data_t'(rand_bits(16)));
        write_reg(mmi_addr_t'(`DAC_REG_EN_MMI), mmi_data_t'(rand_bits(16)));
        addr = mmi_addr_t'(rand_bits(4));
        write_reg(addr | 4'h4, mmi_data_t'(rand_bits(16)));   // 4 and above
        en_mmi_ctrl = 1'b0;
        write_reg(mmi_addr_t'(`DAC_REG_DAC), mmi_data_t'(rand_bits(16)));
        wait_quiet();
        check_value("frames after dropped writes", frames_rx, n_frames);
        for (i = 0; i < 16; i++) begin
            read_expect(mmi_addr_t'(i), expected_read(mmi_addr_t'(i)));
        end

        // gain port while the bus is off
        check_value("gain_ready", gain_ready, 1'b1);
        for (i = 0; i < 6; i++) begin
            n_frames = frames_rx;
            g        = dac_gain_t'(rand_bits(8));
            send_gain(g);
            wait_frames(n_frames + 1);
            check_value("frame gain bits", last_frame[`DAC_GAIN_LSB +: `DAC_GAIN_W], g);
            check_value("frame after gain", last_frame, model_dac);
            read_expect(mmi_addr_t'(`DAC_REG_DAC), expected_read(`DAC_REG_DAC));
        end
        en_mmi_ctrl = 1'b1;
        @(negedge clk_ifc);
        check_value("gain_ready", gain_ready, 1'b0);

        // bursts early, midway and late in a frame
        for (i = 0; i < 3; i++) begin
            en_mmi_ctrl = (rand_bits(1) != 0);
            @(negedge clk_ifc);
            change_dac();
            wait_sync_low();
            repeat (10 + 50 * i + int'(rand_bits(3))) @(negedge clk_ifc);
            repeat (2 + int'(rand_bits(2))) change_dac();
            wait_quiet();
            check_value("last frame", last_frame, model_dac);
        end
        check_value("dac_updated pulses", updates, frames_rx);

        // reset in the middle of a frame
        en_mmi_ctrl = 1'b1;
        change_dac();
        wait_sync_low();
        repeat (40) @(negedge clk_ifc);
        apply_reset();
        n_frames = frames_rx;
        wait_frames(n_frames + 1);
        check_value("frame after reset", last_frame, `DAC_DEFAULT);
        read_expect(mmi_addr_t'(`DAC_REG_DAC), `DAC_DEFAULT);
        wait_quiet();
        check_value("dac_updated pulses", updates, frames_rx);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
hw/mmi_pkg.sv
hw/dac_pkg.sv
hw/dac_ad5601_ctrl_mmi.sv
hw/dac_spi_master.sv
hw/dac_ad5601_subsys.sv
testbench/tb_dac_ad5601_subsys.sv

// File: Bender.yml
package:
  name: dac_ad5601_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/mmi_pkg.sv
      - hw/dac_pkg.sv
      - hw/dac_ad5601_ctrl_mmi.sv
      - hw/dac_spi_master.sv
      - hw/dac_ad5601_subsys.sv
      - target: test
        files:
          - testbench/tb_dac_ad5601_subsys.sv
